//--- hw/sim_config.svh
////////////////////////////////////////////////////////////
// simulation shell configuration
// bus latencies, fixed read word, uart offset, counter width
////////////////////////////////////////////////////////////
`ifndef SIM_CONFIG_SVH
`define SIM_CONFIG_SVH

// edges from the address handshake to the data phase
`define SIM_READ_LATENCY 6
`define SIM_WRITE_LATENCY 6

// word returned on every read
`define SIM_READ_DATA 32'hFFFF_FF21

// low 14 address bits of the uart data register
`define SIM_UART_OFFSET 4096

`define SIM_STAT_W 32

`endif

//--- hw/axi_sim_pkg.sv
////////////////////////////////////////////////////////////
// axi-lite bus types
// shared by the memory responders and the bus interface
////////////////////////////////////////////////////////////
package axi_sim_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0] axi_strb_t;

    // only OKAY is ever returned by the shell
    typedef enum logic [1:0] {
        OKAY = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

endpackage

//--- hw/trace_pkg.sv
////////////////////////////////////////////////////////////
// retire trace types
// opcodes, instruction mix categories, counters, markers
////////////////////////////////////////////////////////////
`include "sim_config.svh"

package trace_pkg;

    typedef logic [31:0] instr_t;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        LOAD = 5'b00000,
        FENCE = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC = 5'b00101,
        STORE = 5'b01000,
        AMO = 5'b01011,
        ARITH = 5'b01100,
        LUI = 5'b01101,
        BRANCH = 5'b11000,
        JALR = 5'b11001,
        JAL = 5'b11011,
        SYSTEM = 5'b11100
    } opcode_t;

    localparam int MIX_CATS = 7;

    typedef enum logic [2:0] {
        MIX_ALU,
        MIX_BRANCH,
        MIX_MUL,
        MIX_DIV,
        MIX_LOAD,
        MIX_STORE,
        MIX_MISC
    } mix_cat_t;

    typedef logic [MIX_CATS-1:0] mix_vec_t;
    typedef logic [`SIM_STAT_W-1:0] stat_count_t;
    typedef stat_count_t [MIX_CATS-1:0] mix_counts_t;

    // addi x0, x0, 12 and addi x0, x0, 13
    localparam instr_t START_MARKER = 32'h00C00013;
    localparam instr_t END_MARKER = 32'h00D00013;

endpackage

//--- hw/axi_lite_if.sv
////////////////////////////////////////////////////////////
// axi-lite bus between the shell top and the responders
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface axi_lite_if;
    import axi_sim_pkg::*;

    // read channels
    axi_addr_t araddr;
    logic arvalid;
    logic arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic rvalid;
    logic rready;

    // write channels
    axi_addr_t awaddr;
    logic awvalid;
    logic awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic wvalid;
    logic wready;
    axi_resp_t bresp;
    logic bvalid;
    logic bready;

    modport read_slave (
        input araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

    modport write_slave (
        input awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bresp, bvalid
    );

endinterface

//--- hw/trace_stat_if.sv
////////////////////////////////////////////////////////////
// retire trace and window control for the profiler
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface trace_stat_if;
    import trace_pkg::*;

    logic retire_valid;
    instr_t retire_instr;
    logic collecting;
    logic clear;

    modport ctrl (
        input retire_valid, retire_instr,
        output collecting, clear
    );

    modport profiler (
        input retire_valid, retire_instr, collecting, clear
    );

endinterface

//--- hw/axi_read_responder.sv
////////////////////////////////////////////////////////////
// axi-lite read responder
// fixed latency, fixed data word, one read outstanding
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sim_config.svh"

module axi_read_responder (
    input logic clk,
    input logic rst,
    axi_lite_if.read_slave bus
);
    import axi_sim_pkg::*;

    localparam int LAT = `SIM_READ_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);

    logic [CNT_W-1:0] count;
    logic pending;

    assign bus.rresp = OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.arready <= 1'b1;
            bus.rvalid <= 1'b0;
            pending <= 1'b0;
            count <= '0;
        end else begin
            if (bus.arvalid && bus.arready) begin
                bus.arready <= 1'b0;
                pending <= 1'b1;
                count <= CNT_W'(LAT - 1);
            end
            // countdown to the data phase
            if (pending) begin
                if (count == '0) begin
                    bus.rvalid <= 1'b1;
                    pending <= 1'b0;
                end else begin
                    count <= count - 1'b1;
                end
            end
            if (bus.rvalid && bus.rready) begin
                bus.rvalid <= 1'b0;
                bus.arready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pending && count == '0) begin
            bus.rdata <= `SIM_READ_DATA;
        end
    end

    // read data held under back-pressure
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bus.rvalid && !bus.rready |=> bus.rvalid);

    // master keeps the address until it is taken
    a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
        bus.arvalid && !bus.arready |=> $stable(bus.araddr));

endmodule

//--- hw/axi_write_responder.sv
////////////////////////////////////////////////////////////
// axi-lite write responder
// fixed latency before data, OKAY response, uart capture
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sim_config.svh"

module axi_write_responder (
    input logic clk,
    input logic rst,
    axi_lite_if.write_slave bus,
    output logic uart_write,
    output logic [7:0] uart_byte
);
    import axi_sim_pkg::*;

    localparam int LAT = `SIM_WRITE_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);

    logic [CNT_W-1:0] count;
    logic pending;
    axi_addr_t addr_q;
    logic data_hs;
    logic uart_hit;

    assign data_hs = bus.wvalid && bus.wready;
    assign uart_hit = (addr_q[13:0] == 14'(`SIM_UART_OFFSET));
    assign bus.bresp = OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.awready <= 1'b1;
            bus.wready <= 1'b0;
            bus.bvalid <= 1'b0;
            pending <= 1'b0;
            count <= '0;
        end else begin
            if (bus.awvalid && bus.awready) begin
                bus.awready <= 1'b0;
                pending <= 1'b1;
                count <= CNT_W'(LAT - 1);
            end
            if (pending) begin
                if (count == '0) begin
                    bus.wready <= 1'b1;
                    pending <= 1'b0;
                end else begin
                    count <= count - 1'b1;
                end
            end
            if (data_hs) begin
                bus.wready <= 1'b0;
                bus.bvalid <= 1'b1;
            end
            // response taken, ready for the next address
            if (bus.bvalid && bus.bready) begin
                bus.bvalid <= 1'b0;
                bus.awready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.awvalid && bus.awready) begin
            addr_q <= bus.awaddr;
        end
    end

    ////////////////////////////////////////////////////////////
    // uart capture

    always_ff @(posedge clk) begin
        if (rst) begin
            uart_write <= 1'b0;
        end else begin
            uart_write <= data_hs && uart_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (data_hs) begin
            uart_byte <= bus.wdata[7:0];
        end
    end

    // address and data phases never overlap
    a_ready_excl: assert property (@(posedge clk) disable iff (rst)
        !(bus.awready && bus.wready));

    a_wstrb_stable: assert property (@(posedge clk) disable iff (rst)
        bus.wvalid && !bus.wready |=> $stable(bus.wstrb));

endmodule

//--- hw/collection_ctrl.sv
////////////////////////////////////////////////////////////
// collection window control
// opens on the start marker nop, closes on the end marker
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module collection_ctrl (
    input logic clk,
    input logic rst,
    trace_stat_if.ctrl stat
);
    import trace_pkg::*;

    logic start_hit;
    logic end_hit;

    assign start_hit = stat.retire_valid && (stat.retire_instr == START_MARKER);
    assign end_hit = stat.retire_valid && (stat.retire_instr == END_MARKER);

    always_ff @(posedge clk) begin
        if (rst) begin
            stat.collecting <= 1'b0;
            stat.clear <= 1'b0;
        end else begin
            // a start inside an open window is ignored
            stat.clear <= start_hit && !stat.collecting;
            if (start_hit) begin
                stat.collecting <= 1'b1;
            end else if (end_hit) begin
                stat.collecting <= 1'b0;
            end
        end
    end

    a_clear_at_open: assert property (@(posedge clk) disable iff (rst)
        stat.clear |-> stat.collecting && !$past(stat.collecting));

endmodule

//--- hw/mix_profiler.sv
////////////////////////////////////////////////////////////
// retire instruction mix profiler
// classifies each retired instruction and counts per category
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_profiler (
    input logic clk,
    input logic rst,
    trace_stat_if.profiler stat,
    output trace_pkg::mix_counts_t mix_counts,
    output trace_pkg::stat_count_t retire_count
);
    import trace_pkg::*;

    opcode_t opcode;
    logic ext_m;
    logic is_mul;
    logic is_div;
    logic count_en;
    mix_vec_t mix;

    assign opcode = opcode_t'(stat.retire_instr[6:2]);

    // bit 25 marks the M extension, bit 14 splits div/rem from mul
    assign ext_m = (opcode == ARITH) && stat.retire_instr[25];
    assign is_mul = ext_m && !stat.retire_instr[14];
    assign is_div = ext_m && stat.retire_instr[14];

    assign count_en = stat.collecting && stat.retire_valid;

    always_comb begin
        mix = '0;
        mix[MIX_ALU] = (opcode inside {ARITH_IMM, AUIPC, LUI})
            || ((opcode == ARITH) && !(is_mul || is_div));
        mix[MIX_BRANCH] = opcode inside {BRANCH, JAL, JALR};
        mix[MIX_MUL] = is_mul;
        mix[MIX_DIV] = is_div;
        // amo is both a load and a store
        mix[MIX_LOAD] = opcode inside {LOAD, AMO};
        mix[MIX_STORE] = opcode inside {STORE, AMO};
        mix[MIX_MISC] = opcode inside {SYSTEM, FENCE};
    end

    ////////////////////////////////////////////////////////////
    // counters, restarted by clear without dropping a retire

    always_ff @(posedge clk) begin
        if (rst) begin
            mix_counts <= '0;
            retire_count <= '0;
        end else begin
            for (int i = 0; i < MIX_CATS; i++) begin
                mix_counts[i] <= (stat.clear ? '0 : mix_counts[i])
                    + stat_count_t'(count_en && mix[i]);
            end
            retire_count <= (stat.clear ? '0 : retire_count) + stat_count_t'(count_en);
        end
    end

endmodule

//--- hw/sim_shell_top.sv
////////////////////////////////////////////////////////////
// simulation shell top
// memory bus responders, uart strobe and retire profiler
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sim_shell_top (
    input logic clk,
    input logic rst,

    // axi read
    input axi_sim_pkg::axi_addr_t araddr,
    input logic arvalid,
    output logic arready,
    output axi_sim_pkg::axi_data_t rdata,
    output axi_sim_pkg::axi_resp_t rresp,
    output logic rvalid,
    input logic rready,

    // axi write
    input axi_sim_pkg::axi_addr_t awaddr,
    input logic awvalid,
    output logic awready,
    input axi_sim_pkg::axi_data_t wdata,
    input axi_sim_pkg::axi_strb_t wstrb,
    input logic wvalid,
    output logic wready,
    output axi_sim_pkg::axi_resp_t bresp,
    output logic bvalid,
    input logic bready,

    output logic uart_write,
    output logic [7:0] uart_byte,

    // retire trace
    input logic retire_valid,
    input trace_pkg::instr_t retire_instr,
    output logic collecting,
    output trace_pkg::mix_counts_t mix_counts,
    output trace_pkg::stat_count_t retire_count
);

    axi_lite_if bus ();
    trace_stat_if stat ();

    assign bus.araddr = araddr;
    assign bus.arvalid = arvalid;
    assign bus.rready = rready;
    assign arready = bus.arready;
    assign rdata = bus.rdata;
    assign rresp = bus.rresp;
    assign rvalid = bus.rvalid;

    assign bus.awaddr = awaddr;
    assign bus.awvalid = awvalid;
    assign bus.wdata = wdata;
    assign bus.wstrb = wstrb;
    assign bus.wvalid = wvalid;
    assign bus.bready = bready;
    assign awready = bus.awready;
    assign wready = bus.wready;
    assign bresp = bus.bresp;
    assign bvalid = bus.bvalid;

    assign stat.retire_valid = retire_valid;
    assign stat.retire_instr = retire_instr;
    assign collecting = stat.collecting;

    axi_read_responder read_inst (
        .clk (clk),
        .rst (rst),
        .bus (bus.read_slave)
    );

    axi_write_responder write_inst (
        .clk (clk),
        .rst (rst),
        .bus (bus.write_slave),
        .uart_write (uart_write),
        .uart_byte (uart_byte)
    );

    collection_ctrl ctrl_inst (
        .clk (clk),
        .rst (rst),
        .stat (stat.ctrl)
    );

    mix_profiler profiler_inst (
        .clk (clk),
        .rst (rst),
        .stat (stat.profiler),
        .mix_counts (mix_counts),
        .retire_count (retire_count)
    );

endmodule

//--- test/sim_shell_tb.sv
////////////////////////////////////////////////////////////
// simulation shell testbench
// directed bus, uart and retire profiler tests
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sim_config.svh"

module sim_shell_tb;
    import axi_sim_pkg::*;
    import trace_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_READS = 6;
    localparam int N_WRITES = 6;
    localparam int MAX_STALL = 5;
    localparam int PHASE_LEN = 40;
    localparam int READ_LAT = `SIM_READ_LATENCY;
    localparam int WRITE_LAT = `SIM_WRITE_LATENCY;
    // each retire may be preceded by one idle cycle
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 200
        + N_READS * (READ_LAT + MAX_STALL + 10)
        + (N_WRITES + 1) * (WRITE_LAT + MAX_STALL + 12)
        + 2 * (4 * PHASE_LEN) + 64;

    logic clk;
    logic rst;
    axi_addr_t araddr;
    logic arvalid;
    logic arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic rvalid;
    logic rready;
    axi_addr_t awaddr;
    logic awvalid;
    logic awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic wvalid;
    logic wready;
    axi_resp_t bresp;
    logic bvalid;
    logic bready;
    logic uart_write;
    logic [7:0] uart_byte;
    logic retire_valid;
    instr_t retire_instr;
    logic collecting;
    mix_counts_t mix_counts;
    stat_count_t retire_count;

    // reference model of the profiler
    stat_count_t exp_counts [MIX_CATS];
    stat_count_t exp_retire;
    logic exp_collecting;

    logic [31:0] lfsr_state = 32'h7db1_7b86;
    int uart_pulses = 0;

    sim_shell_top sim_shell_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // pulse seen at an edge is counted at that edge
    always @(posedge clk) begin
        if (uart_write) begin
            uart_pulses <= uart_pulses + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // random numbers and failure reporting

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic fail_run(input string reason);
        $display("tests failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            fail_run("data value mismatch");
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            fail_run("response mismatch");
        end
    endtask

    task automatic check_count(input string name, input stat_count_t got,
                               input stat_count_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            fail_run("count mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            fail_run("signal level mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus transfers

    task automatic read_transfer(input axi_addr_t addr, input int stall);
        int edges;
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        // address handshake
        @(posedge clk);
        arvalid <= 1'b0;
        edges = 0;
        @(negedge clk);
        check_bit("arready", arready, 1'b0);
        while (!rvalid && edges <= READ_LAT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        check_count("read latency", stat_count_t'(edges), stat_count_t'(READ_LAT));
        check_data("rdata", rdata, `SIM_READ_DATA);
        check_resp("rresp", rresp, OKAY);
        repeat (stall) begin
            @(negedge clk);
            check_bit("rvalid", rvalid, 1'b1);
            check_data("rdata", rdata, `SIM_READ_DATA);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("arready", arready, 1'b1);
    endtask

    task automatic write_transfer(input axi_addr_t addr, input axi_data_t data,
                                  input int stall, input logic to_uart);
        int edges;
        int pulses_before;
        pulses_before = uart_pulses;
        @(posedge clk);
        awaddr <= addr;
        awvalid <= 1'b1;
        wdata <= data;
        wvalid <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        edges = 0;
        @(negedge clk);
        check_bit("awready", awready, 1'b0);
        while (!wready && edges <= WRITE_LAT) begin
            check_bit("uart_write", uart_write, 1'b0);
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        check_count("write latency", stat_count_t'(edges), stat_count_t'(WRITE_LAT));
        // data handshake on the next edge
        @(posedge clk);
        wvalid <= 1'b0;
        @(negedge clk);
        check_bit("wready", wready, 1'b0);
        check_bit("bvalid", bvalid, 1'b1);
        check_resp("bresp", bresp, OKAY);
        check_bit("uart_write", uart_write, to_uart);
        if (to_uart) begin
            check_data("uart_byte", {24'h0, uart_byte}, {24'h0, data[7:0]});
        end
        repeat (stall) begin
            @(negedge clk);
            check_bit("bvalid", bvalid, 1'b1);
            check_bit("uart_write", uart_write, 1'b0);
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("awready", awready, 1'b1);
        check_count("uart pulses", stat_count_t'(uart_pulses - pulses_before),
                    to_uart ? 32'd1 : 32'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // retire trace

    // kinds 0..13, rd never zero so no random pick hits a marker
    function automatic instr_t make_instr(input int kind);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        logic [1:0] f3;
        rd = 5'(rand_bits(4)) + 5'd1;
        rs1 = 5'(rand_bits(5));
        rs2 = 5'(rand_bits(5));
        imm = 12'(rand_bits(12));
        f3 = 2'(rand_bits(2));
        case (kind)
            0: return {imm, rs1, 3'b000, rd, 7'b0010011};
            1: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            2: return {imm, rs1, 3'b000, rd, 7'b0110111};
            3: return {imm, rs1, 3'b000, rd, 7'b0010111};
            4: return {7'b0000000, rs2, rs1, 3'b001, 5'b00000, 7'b1100011};
            5: return {imm, rs1, 3'b000, rd, 7'b1101111};
            6: return {imm, rs1, 3'b000, rd, 7'b1100111};
            7: return {7'b0000001, rs2, rs1, 1'b0, f3, rd, 7'b0110011};
            8: return {7'b0000001, rs2, rs1, 1'b1, f3, rd, 7'b0110011};
            9: return {imm, rs1, 3'b010, rd, 7'b0000011};
            10: return {7'b0000000, rs2, rs1, 3'b010, 5'b00000, 7'b0100011};
            11: return {7'b0000100, rs2, rs1, 3'b010, rd, 7'b0101111};
            12: return {imm, rs1, 3'b010, rd, 7'b1110011};
            default: return {12'h0ff, 5'b00000, 3'b000, 5'b00000, 7'b0001111};
        endcase
    endfunction

    function automatic mix_vec_t kind_mix(input int kind);
        mix_vec_t v;
        v = '0;
        case (kind)
            0, 1, 2, 3: v[MIX_ALU] = 1'b1;
            4, 5, 6: v[MIX_BRANCH] = 1'b1;
            7: v[MIX_MUL] = 1'b1;
            8: v[MIX_DIV] = 1'b1;
            9: v[MIX_LOAD] = 1'b1;
            10: v[MIX_STORE] = 1'b1;
            11: begin
                v[MIX_LOAD] = 1'b1;
                v[MIX_STORE] = 1'b1;
            end
            default: v[MIX_MISC] = 1'b1;
        endcase
        return v;
    endfunction

    function automatic string cat_name(input int i);
        case (i)
            0: return "mix_counts[alu]";
            1: return "mix_counts[branch]";
            2: return "mix_counts[mul]";
            3: return "mix_counts[div]";
            4: return "mix_counts[load]";
            5: return "mix_counts[store]";
            default: return "mix_counts[misc]";
        endcase
    endfunction

    task automatic retire(input instr_t instr, input mix_vec_t cats);
        @(posedge clk);
        retire_valid <= 1'b1;
        retire_instr <= instr;
        if (exp_collecting) begin
            for (int i = 0; i < MIX_CATS; i++) begin
                if (cats[i]) begin
                    exp_counts[i] = exp_counts[i] + 1'b1;
                end
            end
            exp_retire = exp_retire + 1'b1;
        end
        // window opens with zeroed counts
        if (instr == START_MARKER) begin
            if (!exp_collecting) begin
                for (int i = 0; i < MIX_CATS; i++) begin
                    exp_counts[i] = '0;
                end
                exp_retire = '0;
            end
            exp_collecting = 1'b1;
        end else if (instr == END_MARKER) begin
            exp_collecting = 1'b0;
        end
    endtask

    task automatic retire_mix(input int n);
        int kind;
        for (int k = 0; k < n; k++) begin
            kind = int'(rand_bits(4) % 14);
            if (rand_bits(1) == 32'd1) begin
                @(posedge clk);
                retire_valid <= 1'b0;
            end
            retire(make_instr(kind), kind_mix(kind));
        end
    endtask

    // two idle edges so a pending clear has landed
    task automatic compare_profile();
        @(posedge clk);
        retire_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("collecting", collecting, exp_collecting);
        for (int i = 0; i < MIX_CATS; i++) begin
            check_count(cat_name(i), mix_counts[i], exp_counts[i]);
        end
        check_count("retire_count", retire_count, exp_retire);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests

    task automatic reset_values();
        @(negedge clk);
        check_bit("arready", arready, 1'b1);
        check_bit("awready", awready, 1'b1);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("wready", wready, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("uart_write", uart_write, 1'b0);
        compare_profile();
    endtask

    task automatic random_reads();
        for (int n = 0; n < N_READS; n++) begin
            read_transfer(rand_bits(32), int'(rand_bits(2)) + 2);
        end
    endtask

    task automatic plain_writes();
        axi_addr_t addr;
        for (int n = 0; n < N_WRITES; n++) begin
            addr = rand_bits(32);
            if (addr[13:0] == 14'(`SIM_UART_OFFSET)) begin
                addr[0] = ~addr[0];
            end
            write_transfer(addr, rand_bits(32), int'(rand_bits(2)) + 2, 1'b0);
        end
    endtask

    task automatic uart_strobe();
        axi_addr_t addr;
        addr = rand_bits(32);
        addr[13:0] = 14'(`SIM_UART_OFFSET);
        write_transfer(addr, rand_bits(32), int'(rand_bits(2)) + 2, 1'b1);
    endtask

    task automatic mix_window();
        retire_mix(PHASE_LEN);
        compare_profile();
        retire(START_MARKER, kind_mix(0));
        compare_profile();
        retire_mix(PHASE_LEN);
        retire(END_MARKER, kind_mix(0));
        compare_profile();
        retire_mix(PHASE_LEN / 2);
        compare_profile();
    endtask

    task automatic window_restart();
        retire(START_MARKER, kind_mix(0));
        compare_profile();
        retire_mix(PHASE_LEN);
        retire(END_MARKER, kind_mix(0));
        compare_profile();
    endtask

    initial begin
        rst <= 1'b1;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= 4'hf;
        wvalid <= 1'b0;
        bready <= 1'b0;
        retire_valid <= 1'b0;
        retire_instr <= '0;
        exp_collecting = 1'b0;
        exp_retire = '0;
        for (int i = 0; i < MIX_CATS; i++) begin
            exp_counts[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        reset_values();
        random_reads();
        plain_writes();
        uart_strobe();
        mix_window();
        window_restart();
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run("watchdog expired before the tests finished, the DUT appears hung");
    end

endmodule

//--- files.f
+incdir+hw
hw/axi_sim_pkg.sv
hw/trace_pkg.sv
hw/axi_lite_if.sv
hw/trace_stat_if.sv
hw/axi_read_responder.sv
hw/axi_write_responder.sv
hw/collection_ctrl.sv
hw/mix_profiler.sv
hw/sim_shell_top.sv
test/sim_shell_tb.sv

//--- Makefile
# Verilator build and run for the simulation shell testbench

VERILATOR ?= verilator
TOP ?= sim_shell_tb
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= all tests passed
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' files.f)
HDRS := $(wildcard hw/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): files.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f files.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
